//--- ql_io_pkg.sv
`default_nettype none

package ql_io_pkg;

  // ======================================================================
  // Register map of the I/O block
  // ======================================================================
  localparam int IO_ADDR_W = 7;

  localparam logic [IO_ADDR_W-1:0] REG_TIMER0     = 7'h00; // Write clears the timer
  localparam logic [IO_ADDR_W-1:0] REG_TIMER1     = 7'h01; // Write adjusts one byte
  localparam logic [IO_ADDR_W-1:0] REG_TIMER2     = 7'h02;
  localparam logic [IO_ADDR_W-1:0] REG_TIMER3     = 7'h03; // Write sends one IPC bit
  localparam logic [IO_ADDR_W-1:0] REG_IPC_STATUS = 7'h20;
  localparam logic [IO_ADDR_W-1:0] REG_IRQ        = 7'h21; // Read pending, write mask/ack

  // Clocking and field widths
  localparam int DEFAULT_CPU_CLK_HZ = 27_000_000;
  localparam int BEEP_UNIT_US       = 70;
  localparam int RTC_W              = 32;
  localparam int BEEP_DUR_W         = 15;
  localparam int PITCH_W            = 10;

  // Bit positions in the interrupt byte
  localparam int IRQ_IPC_BIT   = 1;
  localparam int IRQ_VSYNC_BIT = 3;
  localparam int IRQ_RTC_BIT   = 5;

  // Modifier keys live in row 7
  localparam int KEY_SHIFT_BIT = 56;
  localparam int KEY_CTRL_BIT  = 57;
  localparam int KEY_ALT_BIT   = 58;

  // ======================================================================
  // Payload types
  // ======================================================================
  typedef logic [63:0] kbd_matrix_t;   // Row n in bits 8n+7..8n
  typedef logic [15:0] reply_word_t;
  typedef logic [63:0] sound_params_t; // Pitch in 63:56

  typedef enum logic [3:0] {
    IPC_STATUS     = 4'd1,
    IPC_READ_KEY   = 4'd8,
    IPC_KEY_ROW    = 4'd9,
    IPC_SET_SOUND  = 4'd10,
    IPC_KILL_SOUND = 4'd11
  } ipc_cmd_t;

  typedef enum logic [1:0] {
    IPC_IDLE,
    IPC_REPLY,  // Host clocks reply bits out
    IPC_PARAM,  // Collecting the key row index
    IPC_SOUND   // Collecting 64 sound bits
  } ipc_state_t;

endpackage

`default_nettype wire

//--- ipc_shifter.sv
`timescale 1ns/1ns
`default_nettype none

// Shift register shared by the IPC reply and sound parameter paths
module ipc_shifter #(
  parameter type payload_t = logic [15:0]
) (
  input  wire           clk_cpu,
  input  wire           reset,
  input  wire           i_load,
  input  wire payload_t i_load_value,
  input  wire           i_shift,
  input  wire           i_bit,
  output payload_t      o_value,
  output logic          o_msb
);

  localparam int W = $bits(payload_t);

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      o_value <= '0;
    end else if (i_load) begin // Load wins over shift
      o_value <= i_load_value;
    end else if (i_shift) begin
      o_value <= {o_value[W-2:0], i_bit};
    end
  end

  // Host always samples the top bit
  assign o_msb = o_value[W-1];

endmodule

`default_nettype wire

//--- ql_rtc_counter.sv
`timescale 1ns/1ns
`default_nettype none

module ql_rtc_counter import ql_io_pkg::*; #(
  parameter int CPU_CLK_HZ = DEFAULT_CPU_CLK_HZ
) (
  input  wire              clk_cpu,
  input  wire              reset,
  input  wire              i_clear,
  input  wire              i_adjust,
  input  wire  [7:0]       i_adjust_byte,
  output logic [RTC_W-1:0] o_seconds
);

  localparam int PRE_W = $clog2(CPU_CLK_HZ);

  logic [PRE_W-1:0] prescale;
  logic [1:0]       adj_ptr;   // Next byte to adjust
  logic             tick;

  // One second worth of clocks
  assign tick = (prescale == PRE_W'(CPU_CLK_HZ - 1));

  always_ff @(posedge clk_cpu) begin
    if (reset || i_clear) begin
      prescale  <= '0;
      adj_ptr   <= '0;
      o_seconds <= '0;
    end else begin
      if (tick) begin
        prescale  <= '0;
        o_seconds <= o_seconds + 1'b1;
      end else begin
        prescale <= prescale + 1'b1;
      end

      // Adjust writes MSB first, later assignment wins over the tick
      if (i_adjust) begin
        o_seconds[{~adj_ptr, 3'b000} +: 8] <= i_adjust_byte;
        adj_ptr                            <= adj_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- ql_beep_timer.sv
`timescale 1ns/1ns
`default_nettype none

module ql_beep_timer import ql_io_pkg::*; #(
  parameter int CPU_CLK_HZ = DEFAULT_CPU_CLK_HZ
) (
  input  wire                  clk_cpu,
  input  wire                  reset,
  input  wire                  i_start,
  input  wire [BEEP_DUR_W-1:0] i_duration,
  input  wire                  i_kill,
  output logic                 o_active
);

  // Clocks per 70 us unit
  localparam int UNIT_CYCLES = int'((longint'(CPU_CLK_HZ) * BEEP_UNIT_US) / 1_000_000);
  localparam int SCALE_W     = $clog2(UNIT_CYCLES + 1);

  logic [SCALE_W-1:0]    scale;
  logic [BEEP_DUR_W-1:0] remaining;
  logic                  endless;   // Zero duration runs until killed
  logic                  unit_done;

  assign unit_done = (scale == SCALE_W'(UNIT_CYCLES - 1));

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      o_active  <= 1'b0;
      endless   <= 1'b0;
      scale     <= '0;
      remaining <= '0;
    end else if (i_kill) begin
      o_active <= 1'b0;
    end else if (i_start) begin
      o_active  <= 1'b1;
      endless   <= (i_duration == '0);
      remaining <= i_duration;
      scale     <= '0;
    end else if (o_active && !endless) begin
      if (unit_done) begin
        scale <= '0;
        if (remaining != '0) remaining <= remaining - 1'b1;
        else                 o_active  <= 1'b0; // Last unit expired
      end else begin
        scale <= scale + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- ql_irq_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module ql_irq_ctrl import ql_io_pkg::*; (
  input  wire        clk_cpu,
  input  wire        reset,
  input  wire        i_vsync,
  input  wire        i_key_event,
  input  wire        i_rtc_tick_bit,
  input  wire        i_write,
  input  wire  [7:0] i_wdata,
  output logic [7:0] o_pending,
  output logic       o_irq_n
);

  logic       vsync_d;
  logic       vsync_fall;
  logic       vsync_flag;
  logic       ipc_flag;
  logic [2:0] mask;

  assign vsync_fall = vsync_d && !i_vsync; // Frame interrupt on falling edge

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      vsync_d    <= 1'b0;
      vsync_flag <= 1'b0;
      ipc_flag   <= 1'b0;
      mask       <= '0;
    end else begin
      vsync_d <= i_vsync;

      // Acknowledge beats a new event in the same cycle
      if (i_write && i_wdata[IRQ_VSYNC_BIT]) vsync_flag <= 1'b0;
      else if (vsync_fall)                   vsync_flag <= 1'b1;

      if (i_write && i_wdata[IRQ_IPC_BIT]) ipc_flag <= 1'b0;
      else if (i_key_event)                ipc_flag <= 1'b1;

      if (i_write) mask <= i_wdata[7:5];
    end
  end

  always_comb begin
    o_pending                = '0;
    o_pending[7:6]           = mask[2:1]; // Spare positions return the mask
    o_pending[4]             = mask[0];
    o_pending[IRQ_RTC_BIT]   = i_rtc_tick_bit;
    o_pending[IRQ_VSYNC_BIT] = vsync_flag;
    o_pending[IRQ_IPC_BIT]   = ipc_flag;
  end

  assign o_irq_n = !(vsync_flag || ipc_flag);

endmodule

`default_nettype wire

//--- ql_ipc_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module ql_ipc_fsm import ql_io_pkg::*; (
  input  wire                   clk_cpu,
  input  wire                   reset,
  input  wire                   i_bit_write,
  input  wire  [7:0]            i_wdata,
  input  wire  kbd_matrix_t     i_kbd_matrix,
  input  wire                   i_key_event,
  input  wire                   i_reply_msb,
  output logic                  o_reply_load,
  output reply_word_t           o_reply_value,
  output logic                  o_reply_shift,
  output logic                  o_sound_shift,
  output logic                  o_bit,
  input  wire  sound_params_t   i_sound,
  output logic                  o_beep_start,
  output logic [BEEP_DUR_W-1:0] o_beep_duration,
  output logic                  o_beep_kill,
  output logic [PITCH_W-1:0]    o_pitch,
  output logic [7:0]            o_status
);

  ipc_state_t    state;
  ipc_state_t    state_next;
  logic [5:0]    bit_cnt;
  logic [5:0]    bit_cnt_next;
  logic [3:0]    reply_last;       // Index of the final reply bit
  logic [3:0]    reply_last_next;
  logic [3:0]    nibble;           // Command or row index being built
  logic [3:0]    nibble_next;
  logic          key_pressed;
  logic          key_taken;
  logic          counted;
  logic [2:0]    key_row;
  logic [2:0]    key_col;
  logic [7:0]    row_byte;
  logic [7:0]    param_row;
  sound_params_t sound_next;

  assign counted     = i_bit_write && !i_wdata[0]; // Bit 0 set marks a non-counted write
  assign o_bit       = i_wdata[1];
  assign nibble_next = {nibble[2:0], o_bit};
  assign sound_next  = {i_sound[62:0], o_bit};     // Value after this shift
  assign param_row   = i_kbd_matrix[{nibble_next[2:0], 3'b000} +: 8];

  assign o_beep_duration = {sound_next[22:16], sound_next[31:24]};
  assign o_status        = {i_reply_msb, 7'b0};

  // ======================================================================
  // Key encoder
  // ======================================================================
  always_comb begin
    key_row = 3'd7;
    for (int r = 7; r >= 0; r--) begin
      if (i_kbd_matrix[8*r +: 8] != 8'h00) key_row = 3'(r); // Lowest row wins
    end
    row_byte = i_kbd_matrix[{key_row, 3'b000} +: 8];
    key_col  = 3'd7;
    for (int c = 7; c >= 0; c--) begin
      if (row_byte[c]) key_col = 3'(c);
    end
  end

  // ======================================================================
  // Protocol decode
  // ======================================================================
  always_comb begin
    state_next      = state;
    bit_cnt_next    = bit_cnt;
    reply_last_next = reply_last;
    o_reply_load    = 1'b0;
    o_reply_value   = '0;
    o_reply_shift   = 1'b0;
    o_sound_shift   = 1'b0;
    o_beep_start    = 1'b0;
    o_beep_kill     = 1'b0;
    key_taken       = 1'b0;
    if (counted) begin
      bit_cnt_next = bit_cnt + 6'd1;
      case (state)
        IPC_IDLE: begin
          if (bit_cnt == 6'd3) begin
            bit_cnt_next = '0;
            case (ipc_cmd_t'(nibble_next))
              IPC_STATUS: begin
                state_next      = IPC_REPLY;
                reply_last_next = 4'd7;
                o_reply_load    = 1'b1;
                o_reply_value   = {7'b0, key_pressed, 8'b0};
                key_taken       = 1'b1;
              end
              IPC_READ_KEY: begin
                state_next      = IPC_REPLY;
                reply_last_next = 4'd15;
                o_reply_load    = 1'b1;
                o_reply_value   = {4'b0001, 1'b0, i_kbd_matrix[KEY_SHIFT_BIT],
                                   i_kbd_matrix[KEY_CTRL_BIT], i_kbd_matrix[KEY_ALT_BIT],
                                   2'b00, ~key_row, key_col};
              end
              IPC_KEY_ROW:    state_next  = IPC_PARAM;
              IPC_SET_SOUND:  state_next  = IPC_SOUND;
              IPC_KILL_SOUND: o_beep_kill = 1'b1;
              default: ; // Other commands need no action
            endcase
          end
        end
        IPC_PARAM: begin
          if (bit_cnt == 6'd3) begin
            state_next      = IPC_REPLY;
            bit_cnt_next    = '0;
            reply_last_next = 4'd7;
            o_reply_load    = 1'b1;
            o_reply_value   = {param_row, 8'h00};
          end
        end
        IPC_REPLY: begin
          o_reply_shift = (bit_cnt != '0); // First bit is already at the top
          if (bit_cnt == {2'b00, reply_last}) begin
            state_next   = IPC_IDLE;
            bit_cnt_next = '0;
          end
        end
        IPC_SOUND: begin
          o_sound_shift = 1'b1;
          if (bit_cnt == 6'd63) begin
            state_next   = IPC_IDLE;
            bit_cnt_next = '0;
            o_beep_start = 1'b1;
          end
        end
        default: state_next = IPC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state       <= IPC_IDLE;
      bit_cnt     <= '0;
      reply_last  <= 4'd7;
      nibble      <= '0;
      key_pressed <= 1'b0;
      o_pitch     <= '0;
    end else begin
      state      <= state_next;
      bit_cnt    <= bit_cnt_next;
      reply_last <= reply_last_next;
      if (counted && (state == IPC_IDLE || state == IPC_PARAM)) nibble <= nibble_next;
      if (o_beep_start) o_pitch <= PITCH_W'(256) - PITCH_W'(sound_next[63:56]);
      if (key_taken)   key_pressed <= 1'b0;
      if (i_key_event) key_pressed <= 1'b1; // A fresh key survives the status read
    end
  end

endmodule

`default_nettype wire

//--- ql_io_top.sv
`timescale 1ns/1ns
`default_nettype none

module ql_io_top import ql_io_pkg::*; #(
  parameter int CPU_CLK_HZ = DEFAULT_CPU_CLK_HZ
) (
  input  wire                 clk_cpu,
  input  wire                 reset,
  input  wire                 i_bus_valid,
  input  wire                 i_bus_write,
  input  wire [IO_ADDR_W-1:0] i_bus_addr,
  input  wire [7:0]           i_bus_wdata,
  input  wire kbd_matrix_t    i_kbd_matrix,
  input  wire                 i_key_event,
  input  wire                 i_vsync,
  output logic                o_bus_ready,
  output logic                o_rsp_valid,
  output logic [7:0]          o_rsp_rdata,
  output logic                o_beep_active,
  output logic [PITCH_W-1:0]  o_beep_pitch,
  output logic                o_ipc_irq_n
);

  logic                  accept;
  logic                  wr_accept;
  logic                  rtc_clear;
  logic                  rtc_adjust;
  logic                  ipc_bit_wr;
  logic                  irq_wr;
  logic [RTC_W-1:0]      seconds;
  logic [7:0]            pending;
  logic [7:0]            ipc_status;
  logic [7:0]            read_byte;
  logic                  reply_load;
  logic                  reply_shift;
  logic                  reply_msb;
  reply_word_t           reply_value;
  logic                  sound_shift;
  logic                  ipc_bit;
  sound_params_t         sound;
  logic                  beep_start;
  logic                  beep_kill;
  logic [BEEP_DUR_W-1:0] beep_duration;

  // ======================================================================
  // Bus handshake and decode
  // ======================================================================
  assign o_bus_ready = !o_rsp_valid; // Busy during the response cycle
  assign accept      = i_bus_valid && o_bus_ready;
  assign wr_accept   = accept && i_bus_write;

  assign rtc_clear  = wr_accept && (i_bus_addr == REG_TIMER0);
  assign rtc_adjust = wr_accept && (i_bus_addr == REG_TIMER1);
  assign ipc_bit_wr = wr_accept && (i_bus_addr == REG_TIMER3);
  assign irq_wr     = wr_accept && (i_bus_addr == REG_IRQ);

  always_comb begin
    case (i_bus_addr)
      REG_TIMER0:     read_byte = seconds[31:24];
      REG_TIMER1:     read_byte = seconds[23:16];
      REG_TIMER2:     read_byte = seconds[15:8];
      REG_TIMER3:     read_byte = seconds[7:0];
      REG_IPC_STATUS: read_byte = ipc_status;
      REG_IRQ:        read_byte = pending;
      default:        read_byte = 8'h00;
    endcase
  end

  always_ff @(posedge clk_cpu) begin
    if (reset) o_rsp_valid <= 1'b0;
    else       o_rsp_valid <= accept;
  end

  always_ff @(posedge clk_cpu) begin
    if (accept) o_rsp_rdata <= i_bus_write ? 8'h00 : read_byte;
  end

  // ======================================================================
  // Function blocks
  // ======================================================================
  ql_rtc_counter #(.CPU_CLK_HZ(CPU_CLK_HZ)) u_rtc (
    .clk_cpu(clk_cpu), .reset(reset),
    .i_clear(rtc_clear), .i_adjust(rtc_adjust), .i_adjust_byte(i_bus_wdata),
    .o_seconds(seconds)
  );

  ql_irq_ctrl u_irq (
    .clk_cpu(clk_cpu), .reset(reset),
    .i_vsync(i_vsync), .i_key_event(i_key_event), .i_rtc_tick_bit(seconds[0]),
    .i_write(irq_wr), .i_wdata(i_bus_wdata),
    .o_pending(pending), .o_irq_n(o_ipc_irq_n)
  );

  ql_ipc_fsm u_ipc_fsm (
    .clk_cpu(clk_cpu), .reset(reset),
    .i_bit_write(ipc_bit_wr), .i_wdata(i_bus_wdata),
    .i_kbd_matrix(i_kbd_matrix), .i_key_event(i_key_event), .i_reply_msb(reply_msb),
    .o_reply_load(reply_load), .o_reply_value(reply_value), .o_reply_shift(reply_shift),
    .o_sound_shift(sound_shift), .o_bit(ipc_bit), .i_sound(sound),
    .o_beep_start(beep_start), .o_beep_duration(beep_duration), .o_beep_kill(beep_kill),
    .o_pitch(o_beep_pitch), .o_status(ipc_status)
  );

  ipc_shifter #(.payload_t(reply_word_t)) u_reply_sr ( // Zeros fill in behind the reply
    .clk_cpu(clk_cpu), .reset(reset),
    .i_load(reply_load), .i_load_value(reply_value),
    .i_shift(reply_shift), .i_bit(1'b0),
    .o_value(), .o_msb(reply_msb)
  );

  ipc_shifter #(.payload_t(sound_params_t)) u_sound_sr (
    .clk_cpu(clk_cpu), .reset(reset),
    .i_load(1'b0), .i_load_value('0),
    .i_shift(sound_shift), .i_bit(ipc_bit),
    .o_value(sound), .o_msb()
  );

  ql_beep_timer #(.CPU_CLK_HZ(CPU_CLK_HZ)) u_beep (
    .clk_cpu(clk_cpu), .reset(reset),
    .i_start(beep_start), .i_duration(beep_duration), .i_kill(beep_kill),
    .o_active(o_beep_active)
  );

endmodule

`default_nettype wire

//--- ql_io_props.sv
`timescale 1ns/1ns
`default_nettype none

module ql_io_props import ql_io_pkg::*; (
  input wire             clk_cpu,
  input wire             reset,
  input wire             i_bus_valid,
  input wire             o_bus_ready,
  input wire             o_rsp_valid,
  input wire             o_beep_active,
  input wire ipc_state_t ipc_state
);

  // Response exactly one cycle after each accepted transfer
  a_rsp_pulse: assert property (@(posedge clk_cpu) disable iff (reset)
    (i_bus_valid && o_bus_ready) |=> o_rsp_valid ##1 !o_rsp_valid)
    else $error("Response pulse wrong after an accepted transfer");

  a_rsp_no_accept: assert property (@(posedge clk_cpu) disable iff (reset)
    !(i_bus_valid && o_bus_ready) |=> !o_rsp_valid)
    else $error("Response without an accepted transfer");

  a_ready_low: assert property (@(posedge clk_cpu) disable iff (reset)
    o_rsp_valid |-> !o_bus_ready)
    else $error("Bus ready high during the response cycle");

  a_beep_rise: assert property (@(posedge clk_cpu) disable iff (reset)
    $rose(o_beep_active) |-> (ipc_state != IPC_SOUND))
    else $error("Beep started while sound bits were still arriving");

endmodule

bind ql_io_top ql_io_props u_props (
  .clk_cpu(clk_cpu), .reset(reset),
  .i_bus_valid(i_bus_valid), .o_bus_ready(o_bus_ready), .o_rsp_valid(o_rsp_valid),
  .o_beep_active(o_beep_active), .ipc_state(u_ipc_fsm.state)
);

`default_nettype wire

//--- tb_ql_io.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ql_io import ql_io_pkg::*; ();

  localparam int SIM_CLK_HZ    = 50_000;
  localparam int BEEP_UNIT_CYC = SIM_CLK_HZ * BEEP_UNIT_US / 1_000_000; // 3 cycles

  typedef enum {
    S_WR, S_RD, S_WAIT, S_SEND, S_REPLY, S_KBD, S_KEYEV, S_VSYNC, S_BEEP, S_PITCH, S_IRQN
  } step_op_t;

  typedef struct {
    step_op_t    op;
    logic [6:0]  off;   // Register offset or bit count
    logic [63:0] data;
    logic [15:0] exp;
  } step_t;

  logic                 clk_cpu;
  logic                 reset;
  logic                 i_bus_valid;
  logic                 i_bus_write;
  logic [IO_ADDR_W-1:0] i_bus_addr;
  logic [7:0]           i_bus_wdata;
  kbd_matrix_t          i_kbd_matrix;
  logic                 i_key_event;
  logic                 i_vsync;
  logic                 o_bus_ready;
  logic                 o_rsp_valid;
  logic [7:0]           o_rsp_rdata;
  logic                 o_beep_active;
  logic [PITCH_W-1:0]   o_beep_pitch;
  logic                 o_ipc_irq_n;

  step_t       steps[$];
  int          seed = 60895;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          total_cost;
  kbd_matrix_t row_matrix;
  int          row_idx;
  int          key_idx;
  logic [7:0]  pitch_a;
  logic [7:0]  pitch_b;
  logic [31:0] rtc_base;

  ql_io_top #(.CPU_CLK_HZ(SIM_CLK_HZ)) u_dut (.*);

  always #5 clk_cpu = !clk_cpu;

  // Watchdog
  always @(posedge clk_cpu) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic add_step(input step_op_t op, input logic [6:0] off,
                          input logic [63:0] data, input logic [15:0] exp);
    step_t s;
    s.op   = op;
    s.off  = off;
    s.data = data;
    s.exp  = exp;
    steps.push_back(s);
  endtask

  function automatic int step_cost(input step_t s);
    case (s.op)
      S_WAIT:  return int'(s.data);
      S_SEND:  return 4 * int'(s.off);
      S_REPLY: return 8 * int'(s.off);
      default: return 4;
    endcase
  endfunction

  // Sound block as the IPC expects it
  function automatic sound_params_t make_sound(input logic [7:0] pitch,
                                               input logic [14:0] dur);
    sound_params_t s;
    s          = '0;
    s[63:56]   = pitch;
    s[31:24]   = dur[7:0];
    s[22:16]   = dur[14:8];
    return s;
  endfunction

  function automatic reply_word_t key_reply(input int k);
    logic [2:0] row;
    logic [2:0] col;
    row = 3'(k / 8);
    col = 3'(k % 8);
    return {4'b0001, 1'b0, k == 56, k == 57, k == 58, 2'b00, ~row, col};
  endfunction

  // ======================================================================
  // Bus access
  // ======================================================================
  task automatic bus_xfer(input logic wr, input logic [6:0] addr, input logic [7:0] data,
                          output logic [7:0] rdata);
    @(posedge clk_cpu);
    i_bus_valid <= 1'b1;
    i_bus_write <= wr;
    i_bus_addr  <= addr;
    i_bus_wdata <= data;
    do @(posedge clk_cpu); while (!o_bus_ready); // Held until accepted
    i_bus_valid <= 1'b0;
    @(posedge clk_cpu);
    check_value("o_rsp_valid", o_rsp_valid, 1'b1);
    rdata = o_rsp_rdata;
  endtask

  task automatic run_step(input step_t s);
    logic [7:0]  rd;
    logic [15:0] word;
    case (s.op)
      S_WR: bus_xfer(1'b1, s.off, s.data[7:0], rd);
      S_RD: begin
        bus_xfer(1'b0, s.off, 8'h00, rd);
        check_value($sformatf("o_rsp_rdata[0x%02h]", s.off), rd, s.exp[7:0]);
      end
      S_WAIT: repeat (int'(s.data)) @(posedge clk_cpu);
      S_SEND: begin
        for (int i = int'(s.off) - 1; i >= 0; i--) begin
          bus_xfer(1'b1, REG_TIMER3, {6'b0, s.data[i], 1'b0}, rd); // Bit in data bit 1
        end
      end
      S_REPLY: begin
        word = '0;
        for (int i = 0; i < int'(s.off); i++) begin
          bus_xfer(1'b1, REG_TIMER3, 8'h00, rd);
          bus_xfer(1'b0, REG_IPC_STATUS, 8'h00, rd);
          check_value("ipc status low bits", rd[6:0], 7'h00);
          word = {word[14:0], rd[7]};
        end
        check_value("ipc reply", word, s.exp);
      end
      S_KBD: begin
        @(posedge clk_cpu);
        i_kbd_matrix <= s.data;
      end
      S_KEYEV: begin
        @(posedge clk_cpu);
        i_key_event <= 1'b1;
        @(posedge clk_cpu);
        i_key_event <= 1'b0;
      end
      S_VSYNC: begin
        @(posedge clk_cpu);
        i_vsync <= 1'b0;
        @(posedge clk_cpu);
        i_vsync <= 1'b1;
      end
      S_BEEP: begin
        @(posedge clk_cpu);
        check_value("o_beep_active", o_beep_active, s.exp[0]);
      end
      S_PITCH: begin
        @(posedge clk_cpu);
        check_value("o_beep_pitch", o_beep_pitch, s.exp[PITCH_W-1:0]);
      end
      S_IRQN: begin
        @(posedge clk_cpu);
        check_value("o_ipc_irq_n", o_ipc_irq_n, s.exp[0]);
      end
      default: ;
    endcase
  endtask

  // ======================================================================
  // Stimulus table
  // ======================================================================
  initial begin
    clk_cpu      = 1'b0;
    reset        = 1'b1;
    i_bus_valid  = 1'b0;
    i_bus_write  = 1'b0;
    i_bus_addr   = '0;
    i_bus_wdata  = '0;
    i_kbd_matrix = '0;
    i_key_event  = 1'b0;
    i_vsync      = 1'b1;

    row_matrix = {$random(seed), $random(seed)};
    row_idx    = $random(seed) & 7;
    key_idx    = $random(seed) & 63;
    pitch_a    = 8'($random(seed));
    pitch_b    = 8'($random(seed));
    rtc_base   = 32'h1234_0000;

    // Timer clear, adjust and one-second step
    add_step(S_RD, REG_IRQ, 0, 8'h00);
    add_step(S_WR, REG_TIMER1, 8'hA5, 0); // Nonzero top byte for the clear to remove
    add_step(S_WR, REG_TIMER0, 0, 0);
    add_step(S_WR, REG_TIMER1, rtc_base[31:24], 0);
    add_step(S_WR, REG_TIMER1, rtc_base[23:16], 0);
    for (int b = 0; b < 4; b++) add_step(S_RD, 7'(b), 0, rtc_base[8*(3-b) +: 8]);
    add_step(S_WAIT, 0, SIM_CLK_HZ, 0);
    for (int b = 0; b < 4; b++) add_step(S_RD, 7'(b), 0, 8'((rtc_base + 1) >> (8*(3-b))));

    // Key row
    add_step(S_KBD, 0, row_matrix, 0);
    add_step(S_SEND, 4, IPC_KEY_ROW, 0);
    add_step(S_SEND, 4, row_idx, 0);
    add_step(S_REPLY, 8, 0, row_matrix[8*row_idx +: 8]);

    // Read key, then status before and after the flag is taken
    add_step(S_KBD, 0, 64'd1 << key_idx, 0);
    add_step(S_SEND, 4, IPC_READ_KEY, 0);
    add_step(S_REPLY, 16, 0, key_reply(key_idx));
    add_step(S_KEYEV, 0, 0, 0);
    add_step(S_SEND, 4, IPC_STATUS, 0);
    add_step(S_REPLY, 8, 0, 16'h0001);
    add_step(S_SEND, 4, IPC_STATUS, 0);
    add_step(S_REPLY, 8, 0, 16'h0000);

    // Timed beep of 3 units
    add_step(S_SEND, 4, IPC_SET_SOUND, 0);
    add_step(S_SEND, 64, make_sound(pitch_a, 15'd2), 0);
    add_step(S_BEEP, 0, 0, 1);
    add_step(S_PITCH, 0, 0, 16'(10'd256 - 10'(pitch_a)));
    add_step(S_WAIT, 0, 3 * BEEP_UNIT_CYC - 6, 0);
    add_step(S_BEEP, 0, 0, 1);
    add_step(S_WAIT, 0, 4, 0);
    add_step(S_BEEP, 0, 0, 0);

    // Endless beep stopped by kill
    add_step(S_SEND, 4, IPC_SET_SOUND, 0);
    add_step(S_SEND, 64, make_sound(pitch_b, 15'd0), 0);
    add_step(S_PITCH, 0, 0, 16'(10'd256 - 10'(pitch_b)));
    add_step(S_WAIT, 0, 40 * BEEP_UNIT_CYC, 0);
    add_step(S_BEEP, 0, 0, 1);
    add_step(S_SEND, 4, IPC_KILL_SOUND, 0);
    add_step(S_BEEP, 0, 0, 0);

    // Interrupts with the timer cleared so the rtc bit reads 0
    add_step(S_WR, REG_TIMER0, 0, 0);
    add_step(S_WR, REG_IRQ, 1 << IRQ_IPC_BIT, 0); // Key event of the status test
    add_step(S_RD, REG_IRQ, 0, 8'h00);
    add_step(S_IRQN, 0, 0, 1);
    add_step(S_VSYNC, 0, 0, 0);
    add_step(S_KEYEV, 0, 0, 0);
    add_step(S_RD, REG_IRQ, 0, (1 << IRQ_VSYNC_BIT) | (1 << IRQ_IPC_BIT));
    add_step(S_IRQN, 0, 0, 0);
    add_step(S_WR, REG_IRQ, (1 << IRQ_VSYNC_BIT) | (1 << IRQ_IPC_BIT), 0);
    add_step(S_RD, REG_IRQ, 0, 8'h00);
    add_step(S_IRQN, 0, 0, 1);

    total_cost = 0;
    foreach (steps[i]) total_cost += step_cost(steps[i]);
    cycle_limit = 2 * total_cost + 150_000;

    repeat (3) @(posedge clk_cpu);
    reset <= 1'b0;
    @(posedge clk_cpu);
    check_value("o_bus_ready", o_bus_ready, 1'b1);
    check_value("o_rsp_valid", o_rsp_valid, 1'b0);
    check_value("o_beep_active", o_beep_active, 1'b0);

    foreach (steps[i]) run_step(steps[i]);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
ql_io_pkg.sv
ipc_shifter.sv
ql_rtc_counter.sv
ql_beep_timer.sv
ql_irq_ctrl.sv
ql_ipc_fsm.sv
ql_io_top.sv
ql_io_props.sv
tb_ql_io.sv

//--- Bender.yml
package:
  name: ql_io

sources:
  - ql_io_pkg.sv
  - ipc_shifter.sv
  - ql_rtc_counter.sv
  - ql_beep_timer.sv
  - ql_irq_ctrl.sv
  - ql_ipc_fsm.sv
  - ql_io_top.sv
  - target: simulation
    files:
      - ql_io_props.sv
      - tb_ql_io.sv
